// ==== Bender.yml ====
package:
  name: vic_scan_doubler

sources:
  - vic_pkg.sv
  - scan_ctrl.sv
  - vga_timing.sv
  - line_buffer.sv
  - vic_scan_doubler.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_vic_scan_doubler.sv

// ==== line_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_buffer
   import vic_pkg::*;
(
   input  logic       clk_dot4x,
   input  logic       rst,
   input  logic       wr_stb,
   input  logic       wr_buf,
   input  raster_x_t  raster_x,
   input  vic_color   pixel_color3,
   input  logic [9:0] h_count,
   input  logic [9:0] hoffset,
   input  logic       active,
   output vic_color   color
);

   // one half per chip line
   vic_color mem0 [line_depth];
   vic_color mem1 [line_depth];

   logic               wr_en_q;
   raster_x_t          wr_addr_q;
   vic_color           wr_data_q;
   logic [line_aw-1:0] rd_addr;
   vic_color           rd_q;
   logic               blank_q;

   // dots are taken on the write slot and stored a clock later,
   // after wr_buf has already swapped for a new line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         wr_en_q <= 1'b0;
      end else begin
         wr_en_q <= wr_stb && (raster_x < line_depth);
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (wr_stb) begin
         wr_addr_q <= raster_x;
         wr_data_q <= pixel_color3;
      end
   end

   always_ff @(posedge clk_dot4x) begin
      if (wr_en_q) begin
         if (wr_buf) begin
            mem1[wr_addr_q] <= wr_data_q;
         end else begin
            mem0[wr_addr_q] <= wr_data_q;
         end
      end
   end

   // replay the finished half, shifted left by hoffset
   assign rd_addr = h_count - hoffset;

   always_ff @(posedge clk_dot4x) begin
      rd_q    <= wr_buf ? mem0[rd_addr] : mem1[rd_addr];
      blank_q <= (h_count < hoffset) || (rd_addr >= line_depth);
   end

   // rd_q and active both lag h_count by one clock
   assign color = (active && !blank_q) ? rd_q : black;

   a_wr_in_range: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      wr_stb |-> (raster_x < line_depth)
   ) else $error("raster_x beyond line buffer");

endmodule

`default_nettype wire

// ==== list.f ====
vic_pkg.sv
scan_ctrl.sv
vga_timing.sv
line_buffer.sv
vic_scan_doubler.sv
tb_clock_gen.sv
tb_vic_scan_doubler.sv

// ==== scan_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_ctrl
   import vic_pkg::*;
(
   input  logic      clk_dot4x,
   input  logic      rst,
   input  raster_x_t raster_x,
   input  raster_y_t raster_y,
   output logic      wr_stb,
   output logic      h_step,
   output logic      wr_buf,
   output logic      frame_sync
);

   // one hot dot phase with the write slot in bit 0
   logic [3:0] phase;
   // half rate toggle for the vga counters
   logic       half;
   logic       line_start;

   assign wr_stb = phase[0];
   assign h_step = half;

   // first dot of a chip line
   assign line_start = wr_stb && (raster_x == '0);

   // top left dot anchors the vga frame
   assign frame_sync = line_start && (raster_y == '0);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         phase <= 4'b0001;
         half  <= 1'b1;
      end else begin
         phase <= {phase[2:0], phase[3]};
         half  <= ~half;
      end
   end

   // swap halves at each new chip line
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         wr_buf <= 1'b0;
      end else if (line_start) begin
         wr_buf <= ~wr_buf;
      end
   end

   // buffer halves only swap on a dot slot
   a_buf_swap_on_stb: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      $changed(wr_buf) |-> $past(wr_stb)
   ) else $error("wr_buf changed outside a write slot");

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk_dot4x,
   output logic rst
);

   // 10 ns period
   initial begin
      clk_dot4x = 1'b0;
      forever #5 clk_dot4x = ~clk_dot4x;
   end

   // power-on reset, 4 cycles
   initial begin
      rst = 1'b1;
      repeat (4) @(posedge clk_dot4x);
      #1 rst = 1'b0;
   end

   // reset again for 4 cycles, released 1 ns after an edge
   task hold_reset;
      @(posedge clk_dot4x);
      #1 rst = 1'b1;
      repeat (4) @(posedge clk_dot4x);
      #1 rst = 1'b0;
   endtask

endmodule

`default_nettype wire

// ==== tb_vic_scan_doubler.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_vic_scan_doubler
   import vic_pkg::*;
();

   logic      clk_dot4x;
   logic      rst;
   chip_t     chip;
   raster_x_t raster_x;
   raster_y_t raster_y;
   vic_color  pixel_color3;
   vga_out_t  video;

   int       checks;
   int       errors;
   int       timeouts;
   vic_color pattern [line_depth];

   tb_clock_gen clk_gen (
      .clk_dot4x (clk_dot4x),
      .rst       (rst)
   );

   vic_scan_doubler uut (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .chip         (chip),
      .raster_x     (raster_x),
      .raster_y     (raster_y),
      .pixel_color3 (pixel_color3),
      .video        (video)
   );

   // expected timing per chip, same field order as vga_timing_t
   function automatic vga_timing_t ref_timing(input chip_t c);
      case (c)
         chip_6567r8:   return {10'd519, 10'd525, 10'd10, 10'd72, 10'd103,
                                10'd512, 10'd515, 10'd502, 10'd20, 10'd52};
         chip_6567r56a: return {10'd511, 10'd523, 10'd10, 10'd71, 10'd102,
                                10'd512, 10'd515, 10'd502, 10'd20, 10'd52};
         default:       return {10'd503, 10'd623, 10'd10, 10'd70, 10'd100,
                                10'd580, 10'd583, 10'd569, 10'd10, 10'd20};
      endcase
   endfunction

   // two clocks per h_count step
   function automatic int line_clocks(input vga_timing_t t);
      return 2 * (int'(t.max_width) + 1);
   endfunction

   function automatic logic probe(input string sig);
      return (sig == "hsync") ? video.hsync : (sig == "vsync") ? video.vsync : video.active;
   endfunction

   task automatic tick;
      @(posedge clk_dot4x);
      #1;
   endtask

   task automatic check_color(input string name, input vic_color exp, input vic_color act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %0d, actual %0d at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_level(input string name, input bit exp, input bit act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %0b, actual %0b at %0t", name, exp, act, $time);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   // step clocks until sig reaches level, spent returns the clocks taken
   task automatic wait_level(input string sig, input logic level, input int limit,
                             output int spent);
      spent = 0;
      while (probe(sig) !== level && spent < limit) begin
         tick();
         spent++;
      end
      if (probe(sig) !== level) begin
         timeouts++;
         $display("timeout: %s did not reach %0b within %0d clocks", sig, level, limit);
      end
   endtask

   // raster values present at release are taken on the first dot slot
   task automatic start_chip(input chip_t c, input raster_x_t x, input raster_y_t y,
                             input vic_color pix);
      chip         = c;
      raster_x     = x;
      raster_y     = y;
      pixel_color3 = pix;
      clk_gen.hold_reset();
   endtask

   // rest of a chip line after dot 0, one dot per 4 clocks
   task automatic feed_line(input int last_x, input bit save);
      int         x;
      logic [3:0] rnd;
      for (x = 1; x <= last_x; x++) begin
         repeat (4) tick();
         rnd          = $urandom();
         raster_x     = raster_x_t'(x);
         pixel_color3 = vic_color'(rnd);
         if (save) begin
            pattern[x] = vic_color'(rnd);
         end
      end
   endtask

   task automatic test_horizontal(input chip_t c);
      vga_timing_t t;
      int          spent;
      int          width;
      t = ref_timing(c);
      start_chip(c, 10'd1, 9'd1, white);
      wait_level("hsync", 1'b0, 4 * line_clocks(t), spent);
      wait_level("hsync", 1'b1, 4 * line_clocks(t), width);
      wait_level("hsync", 1'b0, 4 * line_clocks(t), spent);
      check_count($sformatf("hsync width %s", c.name()),
                  2 * (int'(t.hs_end) - int'(t.hs_sta)), width);
      check_count($sformatf("hsync period %s", c.name()), line_clocks(t), width + spent);
   endtask

   task automatic test_active(input chip_t c);
      vga_timing_t t;
      int          n;
      int          rise_at;
      int          falls;
      logic        prev;
      t       = ref_timing(c);
      start_chip(c, 10'd1, 9'd1, white);
      rise_at = -1;
      falls   = 0;
      prev    = video.active;
      for (n = 1; n <= 3 * line_clocks(t); n++) begin
         tick();
         if (!video.active) begin
            check_color($sformatf("blank color %s", c.name()), black, video.color);
         end
         if (video.active && !prev) begin
            rise_at = n;
         end
         if (!video.active && prev && rise_at >= 0) begin
            check_count($sformatf("active width %s", c.name()),
                        2 * (int'(t.max_width) + 1 - int'(t.ha_sta)), n - rise_at);
            falls++;
         end
         prev = video.active;
      end
      check_level($sformatf("active lines seen %s", c.name()), 1'b1, falls >= 2);
   endtask

   // write one random chip line, then watch it drawn twice
   task automatic test_replay(input chip_t c);
      vga_timing_t t;
      int          w;
      int          j;
      int          h;
      logic [3:0]  rnd;
      bit          act_exp;
      vic_color    pix_exp;
      t          = ref_timing(c);
      w          = int'(t.max_width);
      rnd        = $urandom();
      pattern[0] = vic_color'(rnd);
      start_chip(c, 10'd0, 9'd1, pattern[0]);
      feed_line(w, 1'b1);
      repeat (4) tick();
      raster_x     = 10'd0;
      raster_y     = 9'd2;
      pixel_color3 = black;
      fork
         feed_line(w, 1'b0);
         begin
            for (j = 1; j < 2 * line_clocks(t); j++) begin
               tick();
               // outputs lag the counters by one clock
               h       = (j / 2) % (w + 1);
               act_exp = (h >= int'(t.ha_sta));
               pix_exp = act_exp ? pattern[h - int'(t.hoffset)] : black;
               check_level($sformatf("replay active %s", c.name()), act_exp, video.active);
               check_color($sformatf("replay color %s", c.name()), pix_exp, video.color);
            end
         end
      join
   endtask

   // frame anchor at raster 0,0, then vsync over a whole frame
   task automatic test_frame(input chip_t c, input bit full);
      vga_timing_t t;
      int          lines;
      int          limit;
      int          spent;
      int          width;
      t     = ref_timing(c);
      lines = int'(t.vs_sta) - int'(t.max_height) + int'(t.voffset);
      if (lines < 0) begin
         lines = lines + int'(t.max_height) + 1;
      end
      limit = 2 * (int'(t.max_height) + 1) * line_clocks(t);
      start_chip(c, 10'd0, 9'd0, black);
      repeat (4) tick();
      raster_x = 10'd1;
      raster_y = 9'd1;
      wait_level("vsync", 1'b0, limit, spent);
      check_count($sformatf("resync to vsync %s", c.name()), lines * line_clocks(t), spent + 4);
      if (full) begin
         wait_level("vsync", 1'b1, limit, width);
         wait_level("vsync", 1'b0, limit, spent);
         check_count($sformatf("vsync width %s", c.name()),
                     (int'(t.vs_end) - int'(t.vs_sta)) * line_clocks(t), width);
         check_count($sformatf("frame length %s", c.name()),
                     (int'(t.max_height) + 1) * line_clocks(t), width + spent);
      end
   endtask

   initial begin
      int seed;
      int n;
      checks       = 0;
      errors       = 0;
      timeouts     = 0;
      chip         = chip_6569;
      raster_x     = 10'd1;
      raster_y     = 9'd1;
      pixel_color3 = black;
      seed         = 79794;
      void'($urandom(seed));
      n = 0;
      while (rst !== 1'b0 && n < 100) begin
         tick();
         n++;
      end
      if (rst !== 1'b0) begin
         timeouts++;
         $display("timeout: power-on reset was never released");
      end
      test_horizontal(chip_6569);
      test_horizontal(chip_6567r56a);
      test_horizontal(chip_6567r8);
      test_horizontal(chip_unused);
      test_active(chip_6569);
      test_active(chip_6567r56a);
      test_replay(chip_6569);
      test_replay(chip_6567r8);
      test_frame(chip_6567r8, 1'b1);
      test_frame(chip_6569, 1'b0);
      $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing
   import vic_pkg::*;
(
   input  logic       clk_dot4x,
   input  logic       rst,
   input  chip_t      chip,
   input  logic       h_step,
   input  logic       frame_sync,
   output logic [9:0] h_count,
   output logic [9:0] hoffset,
   output logic       hsync,
   output logic       vsync,
   output logic       active
);

   // timing entry of the chip seen during reset
   vga_timing_t tim;
   logic [9:0]  v_count;
   logic        h_wrap;
   logic        v_wrap;
   logic        hs_on;
   logic        vs_on;
   logic        act_on;

   assign hoffset = tim.hoffset;

   assign h_wrap = (h_count >= tim.max_width);
   assign v_wrap = (v_count >= tim.max_height);

   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         tim <= chip_timing[chip];
      end
   end

   // each chip line spans two of these lines, so lines are drawn twice
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         h_count <= '0;
         v_count <= '0;
      end else begin
         if (h_step) begin
            if (h_wrap) begin
               h_count <= '0;
               if (v_wrap) begin
                  v_count <= '0;
               end else begin
                  v_count <= v_count + 10'd1;
               end
            end else begin
               h_count <= h_count + 10'd1;
            end
         end
         // resync to the chip's frame start
         if (frame_sync) begin
            v_count <= tim.max_height - tim.voffset;
         end
      end
   end

   // decode windows from the current counts
   assign hs_on  = (h_count >= tim.hs_sta) && (h_count < tim.hs_end);
   assign vs_on  = (v_count >= tim.vs_sta) && (v_count < tim.vs_end);
   assign act_on = (h_count >= tim.ha_sta) && (v_count < tim.va_end);

   // sync is active low
   always_ff @(posedge clk_dot4x) begin
      if (rst) begin
         hsync  <= 1'b1;
         vsync  <= 1'b1;
         active <= 1'b0;
      end else begin
         hsync  <= ~hs_on;
         vsync  <= ~vs_on;
         active <= act_on;
      end
   end

   a_h_in_range: assert property (
      @(posedge clk_dot4x) disable iff (rst)
      h_count <= tim.max_width
   ) else $error("h_count beyond line length");

endmodule

`default_nettype wire

// ==== vic_pkg.sv ====
`default_nettype none

package vic_pkg;

   // chip variants as sampled on the chip select pins
   typedef enum logic [1:0] {
      chip_6569     = 2'd0,
      chip_6567r56a = 2'd1,
      chip_6567r8   = 2'd2,
      chip_unused   = 2'd3
   } chip_t;

   // palette indices as emitted by the video chip
   typedef enum logic [3:0] {
      black       = 4'd0,
      white       = 4'd1,
      red         = 4'd2,
      cyan        = 4'd3,
      purple      = 4'd4,
      green       = 4'd5,
      blue        = 4'd6,
      yellow      = 4'd7,
      orange      = 4'd8,
      brown       = 4'd9,
      pink        = 4'd10,
      dark_grey   = 4'd11,
      grey        = 4'd12,
      light_green = 4'd13,
      light_blue  = 4'd14,
      light_grey  = 4'd15
   } vic_color;

   typedef logic [9:0] raster_x_t;
   typedef logic [8:0] raster_y_t;

   // per chip doubled-line timing, all in vga counter units
   typedef struct packed {
      logic [9:0] max_width;
      logic [9:0] max_height;
      logic [9:0] hs_sta;
      logic [9:0] hs_end;
      logic [9:0] ha_sta;
      logic [9:0] vs_sta;
      logic [9:0] vs_end;
      logic [9:0] va_end;
      logic [9:0] hoffset;
      logic [9:0] voffset;
   } vga_timing_t;

   // field order: max_width, max_height, hs_sta, hs_end, ha_sta,
   // vs_sta, vs_end, va_end, hoffset, voffset
   localparam vga_timing_t chip_timing [4] = '{
      // 6569 pal
      '{10'd503, 10'd623, 10'd10, 10'd70, 10'd100,
        10'd580, 10'd583, 10'd569, 10'd10, 10'd20},
      // 6567r56a
      '{10'd511, 10'd523, 10'd10, 10'd71, 10'd102,
        10'd512, 10'd515, 10'd502, 10'd20, 10'd52},
      // 6567r8
      '{10'd519, 10'd525, 10'd10, 10'd72, 10'd103,
        10'd512, 10'd515, 10'd502, 10'd20, 10'd52},
      // unused code falls back to pal
      '{10'd503, 10'd623, 10'd10, 10'd70, 10'd100,
        10'd580, 10'd583, 10'd569, 10'd10, 10'd20}
   };

   // longest line of all variants (6567r8)
   localparam int line_depth = 520;
   localparam int line_aw    = $clog2(line_depth);

   // output bundle towards the palette stage
   typedef struct packed {
      logic     hsync;
      logic     vsync;
      logic     active;
      vic_color color;
   } vga_out_t;

endpackage

`default_nettype wire

// ==== vic_scan_doubler.sv ====
`timescale 1ns/1ps
`default_nettype none

module vic_scan_doubler
   import vic_pkg::*;
(
   input  logic      clk_dot4x,
   input  logic      rst,
   input  chip_t     chip,
   input  raster_x_t raster_x,
   input  raster_y_t raster_y,
   input  vic_color  pixel_color3,
   output vga_out_t  video
);

   logic       wr_stb;
   logic       h_step;
   logic       wr_buf;
   logic       frame_sync;
   logic [9:0] h_count;
   logic [9:0] hoffset;
   logic       hsync;
   logic       vsync;
   logic       active;
   vic_color   color;

   scan_ctrl u_ctrl (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .raster_x   (raster_x),
      .raster_y   (raster_y),
      .wr_stb     (wr_stb),
      .h_step     (h_step),
      .wr_buf     (wr_buf),
      .frame_sync (frame_sync)
   );

   vga_timing u_timing (
      .clk_dot4x  (clk_dot4x),
      .rst        (rst),
      .chip       (chip),
      .h_step     (h_step),
      .frame_sync (frame_sync),
      .h_count    (h_count),
      .hoffset    (hoffset),
      .hsync      (hsync),
      .vsync      (vsync),
      .active     (active)
   );

   line_buffer u_buf (
      .clk_dot4x    (clk_dot4x),
      .rst          (rst),
      .wr_stb       (wr_stb),
      .wr_buf       (wr_buf),
      .raster_x     (raster_x),
      .pixel_color3 (pixel_color3),
      .h_count      (h_count),
      .hoffset      (hoffset),
      .active       (active),
      .color        (color)
   );

   assign video = '{hsync: hsync, vsync: vsync, active: active, color: color};

endmodule

`default_nettype wire
